// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 3
) (
    output logic iCLK,
    output logic iRST
);

    initial begin
        iCLK = 1'b0;
        forever #HALF_PERIOD iCLK = ~iCLK;
    end

    // reset released on a rising edge after a few cycles
    initial begin
        iRST = 1'b1;
        repeat (RESET_CYCLES) @(posedge iCLK);
        iRST <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/laser_cmd_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module laser_cmd_assertions (
    input  logic                      iCLK,
    input  logic                      iRST,
    input  logic                      tok_valid,
    input  logic                      tok_is_instr,
    input  logic                      load,
    input  logic                      seq_trigger,
    input  logic                      error,
    input  laser_cmd_pkg::seq_state_t state
);

    // read by the testbench at the end of the run
    int unsigned assert_fails = 0;

    // ========================================
    // sequencer properties
    // ========================================

    // trigger is a single-cycle pulse and is always followed by wait-ack
    trigger_pulse: assert property (@(posedge iCLK) disable iff (iRST)
        seq_trigger |=> (!seq_trigger && state == laser_cmd_pkg::ST_WAIT_ACK))
    else begin
        $error("seq_trigger not a single pulse followed by the wait-ack state");
        assert_fails++;
    end

    // outside the error state, error can only rise after a strobed token
    error_level: assert property (@(posedge iCLK) disable iff (iRST)
        (state != laser_cmd_pkg::ST_ERROR && !tok_valid) |=> !error)
    else begin
        $error("error rose outside the error state without a strobed token");
        assert_fails++;
    end

    // only a strobed data token in a data-wait state may write a bank
    load_on_data: assert property (@(posedge iCLK) disable iff (iRST)
        load |-> (tok_valid && !tok_is_instr && state inside {
            laser_cmd_pkg::ST_OFFSET_MAG, laser_cmd_pkg::ST_OFFSET_SIGN,
            laser_cmd_pkg::ST_DISP_LO, laser_cmd_pkg::ST_DISP_HI,
            laser_cmd_pkg::ST_GALVO_B0, laser_cmd_pkg::ST_GALVO_B1,
            laser_cmd_pkg::ST_GALVO_B2}))
    else begin
        $error("load is high without a strobed data token in a data-wait state");
        assert_fails++;
    end

endmodule

bind cmd_sequencer laser_cmd_assertions seq_assert_i (
    .iCLK         (iCLK),
    .iRST         (iRST),
    .tok_valid    (tok_valid),
    .tok_is_instr (tok_is_instr),
    .load         (load),
    .seq_trigger  (seq_trigger),
    .error        (error),
    .state        (state)
);

`default_nettype wire

// ==== bench/laser_cmd_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "laser_cmd_params.svh"

module laser_cmd_tb;

    localparam int MAX_ROWS  = 72;
    localparam int MAX_GAP   = 3;
    localparam int NUM_TESTS = 7;
    // a row takes at most its gap plus two cycles
    localparam int TIMEOUT_CYCLES = MAX_ROWS * (MAX_GAP + 2) + 40;

    // check selectors
    localparam int CHK_NONE   = 0;
    localparam int CHK_H_OFS  = 1;
    localparam int CHK_H_SIGN = 2;
    localparam int CHK_V_OFS  = 3;
    localparam int CHK_V_SIGN = 4;
    localparam int CHK_DISP   = 5;
    localparam int CHK_GX     = 6;
    localparam int CHK_GY     = 7;
    localparam int CHK_TRIG   = 8;
    localparam int CHK_ERR    = 9;
    localparam int CHK_STATE  = 10;

    logic                        iCLK;
    logic                        iRST;
    logic                        tok_valid;
    logic                        tok_is_instr;
    laser_cmd_pkg::byte_t        tok_byte;
    laser_cmd_pkg::byte_t        h_offset;
    laser_cmd_pkg::byte_t        v_offset;
    logic                        h_offset_sign;
    logic                        v_offset_sign;
    laser_cmd_pkg::disp_cycles_t display_cycles;
    laser_cmd_pkg::galvo_t       galvo_x;
    laser_cmd_pkg::galvo_t       galvo_y;
    logic                        seq_trigger;
    logic                        error;
    laser_cmd_pkg::seq_state_t   monitor_state;

    // ========================================
    // stimulus table
    // ========================================

    int          row_test  [MAX_ROWS];
    logic        row_valid [MAX_ROWS];
    logic        row_instr [MAX_ROWS];
    logic [7:0]  row_byte  [MAX_ROWS];
    int          row_sel   [MAX_ROWS];
    logic [31:0] row_exp   [MAX_ROWS];
    int          row_count   = 0;
    string       test_name [NUM_TESTS];

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    clock_gen clock_gen_i (
        .iCLK (iCLK),
        .iRST (iRST)
    );

    laser_cmd_top laser_cmd_top_i (
        .iCLK           (iCLK),
        .iRST           (iRST),
        .tok_valid      (tok_valid),
        .tok_is_instr   (tok_is_instr),
        .tok_byte       (tok_byte),
        .h_offset       (h_offset),
        .v_offset       (v_offset),
        .h_offset_sign  (h_offset_sign),
        .v_offset_sign  (v_offset_sign),
        .display_cycles (display_cycles),
        .galvo_x        (galvo_x),
        .galvo_y        (galvo_y),
        .seq_trigger    (seq_trigger),
        .error          (error),
        .monitor_state  (monitor_state)
    );

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_selected(input int sel, input logic [31:0] expected);
        case (sel)
            CHK_H_OFS:  compare_values("h_offset", h_offset, expected);
            CHK_H_SIGN: compare_values("h_offset_sign", h_offset_sign, expected);
            CHK_V_OFS:  compare_values("v_offset", v_offset, expected);
            CHK_V_SIGN: compare_values("v_offset_sign", v_offset_sign, expected);
            CHK_DISP:   compare_values("display_cycles", display_cycles, expected);
            CHK_GX:     compare_values("galvo_x", galvo_x, expected);
            CHK_GY:     compare_values("galvo_y", galvo_y, expected);
            CHK_TRIG:   compare_values("seq_trigger", seq_trigger, expected);
            CHK_ERR:    compare_values("error", error, expected);
            CHK_STATE:  compare_values("monitor_state", monitor_state, expected);
            default: ;
        endcase
    endtask

    task automatic add_row(input int test, input logic valid, input logic instr,
                           input logic [7:0] value, input int sel,
                           input logic [31:0] expected);
        if (row_count >= MAX_ROWS) begin
            error_count++;
            $display("stimulus table is full, row for test %0d dropped", test);
        end else begin
            row_test[row_count]  = test;
            row_valid[row_count] = valid;
            row_instr[row_count] = instr;
            row_byte[row_count]  = value;
            row_sel[row_count]   = sel;
            row_exp[row_count]   = expected;
            row_count++;
        end
    endtask

    task automatic push_instr(input int test, input logic [7:0] op, input int sel,
                              input logic [31:0] expected);
        add_row(test, 1'b1, 1'b1, op, sel, expected);
    endtask

    task automatic push_data(input int test, input logic [7:0] value, input int sel,
                             input logic [31:0] expected);
        add_row(test, 1'b1, 1'b0, value, sel, expected);
    endtask

    // a row without a token, for a further check one cycle later
    task automatic push_wait(input int test, input int sel, input logic [31:0] expected);
        add_row(test, 1'b0, 1'b0, 8'h00, sel, expected);
    endtask

    task automatic build_table();
        test_name[0] = "reset values";
        test_name[1] = "image offsets";
        test_name[2] = "display cycles";
        test_name[3] = "galvo positions";
        test_name[4] = "start sequence";
        test_name[5] = "protocol errors";
        test_name[6] = "data while idle";

        push_wait(0, CHK_STATE, laser_cmd_pkg::ST_IDLE);
        push_wait(0, CHK_ERR, 0);
        push_wait(0, CHK_TRIG, 0);
        push_wait(0, CHK_H_OFS, 0);
        push_wait(0, CHK_V_OFS, 0);
        push_wait(0, CHK_DISP, 0);
        push_wait(0, CHK_GX, 0);
        push_wait(0, CHK_GY, 0);

        push_instr(1, `LC_OP_OFFSET_H, CHK_STATE, laser_cmd_pkg::ST_OFFSET_MAG);
        push_data(1, 8'h45, CHK_H_OFS, 32'h45);
        push_data(1, 8'h01, CHK_H_SIGN, 1);
        push_wait(1, CHK_V_OFS, 0);
        push_wait(1, CHK_V_SIGN, 0);
        push_instr(1, `LC_OP_ACK, CHK_STATE, laser_cmd_pkg::ST_IDLE);
        push_instr(1, `LC_OP_OFFSET_V, CHK_STATE, laser_cmd_pkg::ST_OFFSET_MAG);
        // top bit set, so the magnitude clips
        push_data(1, 8'hC3, CHK_V_OFS, 128);
        push_data(1, 8'h01, CHK_V_SIGN, 1);
        push_instr(1, `LC_OP_ACK, CHK_H_OFS, 32'h45);
        push_wait(1, CHK_H_SIGN, 1);

        push_instr(2, `LC_OP_DISPLAY_CYC, CHK_STATE, laser_cmd_pkg::ST_DISP_LO);
        push_data(2, 8'h34, CHK_DISP, 32'h0034);
        push_data(2, 8'h12, CHK_DISP, 32'h1234);
        push_wait(2, CHK_STATE, laser_cmd_pkg::ST_WAIT_ACK);
        push_instr(2, `LC_OP_ACK, CHK_STATE, laser_cmd_pkg::ST_IDLE);

        push_instr(3, `LC_OP_GALVO_X, CHK_STATE, laser_cmd_pkg::ST_GALVO_B0);
        push_data(3, 8'h01, CHK_GX, 32'h000001);
        push_data(3, 8'h02, CHK_GX, 32'h000201);
        push_data(3, 8'h03, CHK_GX, 32'h030201);
        push_instr(3, `LC_OP_ACK, CHK_STATE, laser_cmd_pkg::ST_IDLE);
        push_instr(3, `LC_OP_GALVO_Y, CHK_STATE, laser_cmd_pkg::ST_GALVO_B0);
        push_data(3, 8'hAA, CHK_GY, 32'h0000AA);
        push_data(3, 8'hBB, CHK_GY, 32'h00BBAA);
        push_data(3, 8'hCC, CHK_GY, 32'hCCBBAA);
        push_wait(3, CHK_GX, 32'h030201);
        push_instr(3, `LC_OP_ACK, CHK_STATE, laser_cmd_pkg::ST_IDLE);

        push_instr(4, `LC_OP_START_SEQ, CHK_TRIG, 1);
        push_wait(4, CHK_TRIG, 0);
        push_wait(4, CHK_STATE, laser_cmd_pkg::ST_WAIT_ACK);
        push_instr(4, `LC_OP_ACK, CHK_STATE, laser_cmd_pkg::ST_IDLE);

        push_instr(5, `LC_OP_DISPLAY_CYC, CHK_STATE, laser_cmd_pkg::ST_DISP_LO);
        push_data(5, 8'h78, CHK_DISP, 32'h1278);
        push_data(5, 8'h56, CHK_DISP, 32'h5678);
        // data where an ack is due
        push_data(5, 8'h99, CHK_ERR, 1);
        push_wait(5, CHK_DISP, 32'h5678);
        push_instr(5, `LC_OP_IDLE, CHK_ERR, 0);
        push_instr(5, 8'h2A, CHK_ERR, 1);
        push_wait(5, CHK_STATE, laser_cmd_pkg::ST_ERROR);
        push_instr(5, `LC_OP_IDLE, CHK_ERR, 0);
        push_instr(5, `LC_OP_GALVO_X, CHK_STATE, laser_cmd_pkg::ST_GALVO_B0);
        push_data(5, 8'h11, CHK_GX, 32'h030211);
        push_data(5, 8'h22, CHK_GX, 32'h032211);
        // new command before the last galvo byte
        push_instr(5, `LC_OP_DISPLAY_CYC, CHK_ERR, 1);
        push_wait(5, CHK_GX, 32'h032211);
        push_instr(5, `LC_OP_ACK, CHK_ERR, 1);
        push_instr(5, `LC_OP_GALVO_Y, CHK_STATE, laser_cmd_pkg::ST_GALVO_B0);
        push_instr(5, `LC_OP_IDLE, CHK_STATE, laser_cmd_pkg::ST_IDLE);
        push_wait(5, CHK_GY, 32'hCCBBAA);

        push_data(6, 8'h5A, CHK_STATE, laser_cmd_pkg::ST_IDLE);
        push_data(6, 8'hFF, CHK_DISP, 32'h5678);
        push_data(6, 8'h33, CHK_GY, 32'hCCBBAA);
        push_wait(6, CHK_H_OFS, 32'h45);
        push_wait(6, CHK_V_OFS, 128);
        push_wait(6, CHK_GX, 32'h032211);
        push_wait(6, CHK_ERR, 0);
    endtask

    // ========================================
    // row sequencing
    // ========================================

    // token on one edge, strobe dropped on the next, outputs sampled mid-cycle
    task automatic apply_row(input int idx);
        int gap;
        if (row_valid[idx]) begin
            gap = $urandom % (MAX_GAP + 1);
            repeat (gap) @(posedge iCLK);
            @(posedge iCLK);
            tok_valid    <= 1'b1;
            tok_is_instr <= row_instr[idx];
            tok_byte     <= row_byte[idx];
            @(posedge iCLK);
            tok_valid    <= 1'b0;
        end else begin
            @(posedge iCLK);
        end
        @(negedge iCLK);
        check_selected(row_sel[idx], row_exp[idx]);
    endtask

    always @(posedge iCLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int          mark;
        int          tests_done;
        int unsigned assert_errors;
        tok_valid    = 1'b0;
        tok_is_instr = 1'b0;
        tok_byte     = '0;
        mark         = 0;
        tests_done   = 0;
        void'($urandom(32'h9c583e75));
        build_table();

        @(negedge iRST);
        @(negedge iCLK);

        for (int i = 0; i < row_count; i++) begin
            apply_row(i);
            if (i == row_count - 1 || row_test[i + 1] != row_test[i]) begin
                if (error_count == mark)
                    $display("test %0d %s: ok", row_test[i], test_name[row_test[i]]);
                else
                    $display("test %0d %s: %0d mismatches", row_test[i],
                             test_name[row_test[i]], error_count - mark);
                mark = error_count;
                tests_done++;
            end
        end

        assert_errors = laser_cmd_top_i.cmd_sequencer_i.seq_assert_i.assert_fails;
        $display("summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 tests_done, check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/laser_cmd_pkg.sv
src/cmd_sequencer.sv
src/offset_bank.sv
src/scan_bank.sv
src/laser_cmd_top.sv
bench/clock_gen.sv
bench/laser_cmd_assertions.sv
bench/laser_cmd_tb.sv

// ==== src/cmd_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "laser_cmd_params.svh"

module cmd_sequencer (
    input  logic                      iCLK,
    input  logic                      iRST,
    input  logic                      tok_valid,
    input  logic                      tok_is_instr,
    input  laser_cmd_pkg::byte_t      tok_byte,
    output logic                      load,
    output laser_cmd_pkg::field_t     field,
    output laser_cmd_pkg::byte_t      load_byte,
    output logic                      seq_trigger,
    output logic                      error,
    output laser_cmd_pkg::seq_state_t state
);

    logic                      instr_tok;
    logic                      data_tok;
    laser_cmd_pkg::seq_state_t state_next;
    laser_cmd_pkg::seq_state_t cmd_state;
    laser_cmd_pkg::seq_state_t data_next;
    logic                      cmd_axis;
    logic                      data_wait;
    // 1 selects H (offset) or X (galvo), 0 selects V or Y
    logic                      axis_q;

    assign instr_tok = tok_valid && tok_is_instr;
    assign data_tok  = tok_valid && !tok_is_instr;

    // ========================================
    // opcode decode
    // ========================================

    // ack and unknown opcodes both land in the error state
    always_comb begin
        cmd_state = laser_cmd_pkg::ST_ERROR;
        cmd_axis  = 1'b0;
        case (tok_byte)
            `LC_OP_IDLE:        cmd_state = laser_cmd_pkg::ST_IDLE;
            `LC_OP_OFFSET_H: begin
                cmd_state = laser_cmd_pkg::ST_OFFSET_MAG;
                cmd_axis  = 1'b1;
            end
            `LC_OP_OFFSET_V:    cmd_state = laser_cmd_pkg::ST_OFFSET_MAG;
            `LC_OP_DISPLAY_CYC: cmd_state = laser_cmd_pkg::ST_DISP_LO;
            `LC_OP_START_SEQ:   cmd_state = laser_cmd_pkg::ST_START_TRIGGER;
            `LC_OP_GALVO_X: begin
                cmd_state = laser_cmd_pkg::ST_GALVO_B0;
                cmd_axis  = 1'b1;
            end
            `LC_OP_GALVO_Y:     cmd_state = laser_cmd_pkg::ST_GALVO_B0;
            default:            cmd_state = laser_cmd_pkg::ST_ERROR;
        endcase
    end

    // ========================================
    // data-wait states and field select
    // ========================================

    always_comb begin
        data_wait = 1'b1;
        data_next = laser_cmd_pkg::ST_WAIT_ACK;
        field     = laser_cmd_pkg::F_OFS_H_MAG;
        case (state)
            laser_cmd_pkg::ST_OFFSET_MAG: begin
                data_next = laser_cmd_pkg::ST_OFFSET_SIGN;
                field     = axis_q ? laser_cmd_pkg::F_OFS_H_MAG : laser_cmd_pkg::F_OFS_V_MAG;
            end
            laser_cmd_pkg::ST_OFFSET_SIGN: begin
                field = axis_q ? laser_cmd_pkg::F_OFS_H_SIGN : laser_cmd_pkg::F_OFS_V_SIGN;
            end
            laser_cmd_pkg::ST_DISP_LO: begin
                data_next = laser_cmd_pkg::ST_DISP_HI;
                field     = laser_cmd_pkg::F_DISP_LO;
            end
            laser_cmd_pkg::ST_DISP_HI: field = laser_cmd_pkg::F_DISP_HI;
            laser_cmd_pkg::ST_GALVO_B0: begin
                data_next = laser_cmd_pkg::ST_GALVO_B1;
                field     = axis_q ? laser_cmd_pkg::F_GX_B0 : laser_cmd_pkg::F_GY_B0;
            end
            laser_cmd_pkg::ST_GALVO_B1: begin
                data_next = laser_cmd_pkg::ST_GALVO_B2;
                field     = axis_q ? laser_cmd_pkg::F_GX_B1 : laser_cmd_pkg::F_GY_B1;
            end
            laser_cmd_pkg::ST_GALVO_B2: begin
                field = axis_q ? laser_cmd_pkg::F_GX_B2 : laser_cmd_pkg::F_GY_B2;
            end
            default: data_wait = 1'b0;
        endcase
    end

    // the bank writes in the strobe cycle, so load stays combinational
    assign load      = data_tok && data_wait;
    assign load_byte = tok_byte;

    // ========================================
    // next state
    // ========================================

    always_comb begin
        state_next = state;
        case (state)
            laser_cmd_pkg::ST_IDLE, laser_cmd_pkg::ST_ERROR: begin
                // data tokens are dropped here
                if (instr_tok)
                    state_next = cmd_state;
            end
            laser_cmd_pkg::ST_WAIT_ACK: begin
                if (instr_tok && tok_byte == `LC_OP_ACK)
                    state_next = laser_cmd_pkg::ST_IDLE;
                else if (tok_valid)
                    state_next = laser_cmd_pkg::ST_ERROR;
            end
            laser_cmd_pkg::ST_START_TRIGGER: state_next = laser_cmd_pkg::ST_WAIT_ACK;
            default: begin
                if (!data_wait)
                    state_next = laser_cmd_pkg::ST_IDLE;
                else if (instr_tok)
                    state_next = (tok_byte == `LC_OP_IDLE) ? laser_cmd_pkg::ST_IDLE
                                                            : laser_cmd_pkg::ST_ERROR;
                else if (data_tok)
                    state_next = data_next;
            end
        endcase
    end

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            state  <= laser_cmd_pkg::ST_IDLE;
            axis_q <= 1'b0;
        end else begin
            state <= state_next;
            // axis is latched only when a new command is taken
            if (instr_tok && (state == laser_cmd_pkg::ST_IDLE || state == laser_cmd_pkg::ST_ERROR))
                axis_q <= cmd_axis;
        end
    end

    assign seq_trigger = (state == laser_cmd_pkg::ST_START_TRIGGER);
    assign error       = (state == laser_cmd_pkg::ST_ERROR);

endmodule

`default_nettype wire

// ==== src/laser_cmd_params.svh ====
`ifndef LASER_CMD_PARAMS_SVH
`define LASER_CMD_PARAMS_SVH

// ========================================
// widths
// ========================================

// one host token carries one byte
`define LC_BYTE_W          8
`define LC_DISP_W          16
`define LC_GALVO_W         24

// offset magnitude is clipped to this value once bit 7 is set
`define LC_OFFSET_MAX      8'd128

// ========================================
// instruction opcodes
// ========================================

`define LC_OP_IDLE         8'd0
`define LC_OP_ACK          8'd1
`define LC_OP_OFFSET_H     8'd2
`define LC_OP_OFFSET_V     8'd3
`define LC_OP_DISPLAY_CYC  8'd4
`define LC_OP_START_SEQ    8'd5
`define LC_OP_GALVO_X      8'd6
`define LC_OP_GALVO_Y      8'd7

`endif

// ==== src/laser_cmd_pkg.sv ====
`default_nettype none

`include "laser_cmd_params.svh"

package laser_cmd_pkg;

    typedef logic [`LC_BYTE_W-1:0]  byte_t;
    typedef logic [`LC_DISP_W-1:0]  disp_cycles_t;
    typedef logic [`LC_GALVO_W-1:0] galvo_t;

    // sequencer states, exported for monitoring
    typedef enum logic [4:0] {
        ST_IDLE          = 5'd0,
        ST_ERROR         = 5'd1,
        ST_WAIT_ACK      = 5'd2,
        ST_OFFSET_MAG    = 5'd3,
        ST_OFFSET_SIGN   = 5'd4,
        ST_DISP_LO       = 5'd5,
        ST_DISP_HI       = 5'd6,
        ST_START_TRIGGER = 5'd7,
        ST_GALVO_B0      = 5'd8,
        ST_GALVO_B1      = 5'd9,
        ST_GALVO_B2      = 5'd10
    } seq_state_t;

    // register byte targeted by a data token
    typedef enum logic [3:0] {
        F_OFS_H_MAG  = 4'd0,
        F_OFS_H_SIGN = 4'd1,
        F_OFS_V_MAG  = 4'd2,
        F_OFS_V_SIGN = 4'd3,
        F_DISP_LO    = 4'd4,
        F_DISP_HI    = 4'd5,
        F_GX_B0      = 4'd6,
        F_GX_B1      = 4'd7,
        F_GX_B2      = 4'd8,
        F_GY_B0      = 4'd9,
        F_GY_B1      = 4'd10,
        F_GY_B2      = 4'd11
    } field_t;

endpackage

`default_nettype wire

// ==== src/laser_cmd_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module laser_cmd_top (
    input  logic                        iCLK,
    input  logic                        iRST,
    input  logic                        tok_valid,
    input  logic                        tok_is_instr,
    input  laser_cmd_pkg::byte_t        tok_byte,
    output laser_cmd_pkg::byte_t        h_offset,
    output laser_cmd_pkg::byte_t        v_offset,
    output logic                        h_offset_sign,
    output logic                        v_offset_sign,
    output laser_cmd_pkg::disp_cycles_t display_cycles,
    output laser_cmd_pkg::galvo_t       galvo_x,
    output laser_cmd_pkg::galvo_t       galvo_y,
    output logic                        seq_trigger,
    output logic                        error,
    output laser_cmd_pkg::seq_state_t   monitor_state
);

    // byte-load bus shared by both banks
    logic                  seq_load;
    laser_cmd_pkg::field_t seq_field;
    laser_cmd_pkg::byte_t  seq_byte;

    // ========================================
    // command sequencer
    // ========================================

    cmd_sequencer cmd_sequencer_i (
        .iCLK         (iCLK),
        .iRST         (iRST),
        .tok_valid    (tok_valid),
        .tok_is_instr (tok_is_instr),
        .tok_byte     (tok_byte),
        .load         (seq_load),
        .field        (seq_field),
        .load_byte    (seq_byte),
        .seq_trigger  (seq_trigger),
        .error        (error),
        .state        (monitor_state)
    );

    // ========================================
    // register banks
    // ========================================

    offset_bank offset_bank_i (
        .iCLK          (iCLK),
        .iRST          (iRST),
        .load          (seq_load),
        .field         (seq_field),
        .load_byte     (seq_byte),
        .h_offset      (h_offset),
        .v_offset      (v_offset),
        .h_offset_sign (h_offset_sign),
        .v_offset_sign (v_offset_sign)
    );

    scan_bank scan_bank_i (
        .iCLK           (iCLK),
        .iRST           (iRST),
        .load           (seq_load),
        .field          (seq_field),
        .load_byte      (seq_byte),
        .display_cycles (display_cycles),
        .galvo_x        (galvo_x),
        .galvo_y        (galvo_y)
    );

endmodule

`default_nettype wire

// ==== src/offset_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "laser_cmd_params.svh"

module offset_bank (
    input  logic                  iCLK,
    input  logic                  iRST,
    input  logic                  load,
    input  laser_cmd_pkg::field_t field,
    input  laser_cmd_pkg::byte_t  load_byte,
    output laser_cmd_pkg::byte_t  h_offset,
    output laser_cmd_pkg::byte_t  v_offset,
    output logic                  h_offset_sign,
    output logic                  v_offset_sign
);

    // raw magnitudes as sent by the host
    laser_cmd_pkg::byte_t h_mag_q;
    laser_cmd_pkg::byte_t v_mag_q;

    // clip anything with the top bit set
    function automatic laser_cmd_pkg::byte_t sat_mag(input laser_cmd_pkg::byte_t raw);
        if (raw[`LC_BYTE_W-1])
            return `LC_OFFSET_MAX;
        return raw;
    endfunction

    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            h_mag_q       <= '0;
            v_mag_q       <= '0;
            h_offset_sign <= 1'b0;
            v_offset_sign <= 1'b0;
        end else if (load) begin
            case (field)
                laser_cmd_pkg::F_OFS_H_MAG:  h_mag_q <= load_byte;
                laser_cmd_pkg::F_OFS_V_MAG:  v_mag_q <= load_byte;
                // sign lives in bit 0 of the second byte
                laser_cmd_pkg::F_OFS_H_SIGN: h_offset_sign <= load_byte[0];
                laser_cmd_pkg::F_OFS_V_SIGN: v_offset_sign <= load_byte[0];
                default: ;
            endcase
        end
    end

    assign h_offset = sat_mag(h_mag_q);
    assign v_offset = sat_mag(v_mag_q);

endmodule

`default_nettype wire

// ==== src/scan_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "laser_cmd_params.svh"

module scan_bank (
    input  logic                        iCLK,
    input  logic                        iRST,
    input  logic                        load,
    input  laser_cmd_pkg::field_t       field,
    input  laser_cmd_pkg::byte_t        load_byte,
    output laser_cmd_pkg::disp_cycles_t display_cycles,
    output laser_cmd_pkg::galvo_t       galvo_x,
    output laser_cmd_pkg::galvo_t       galvo_y
);

    // ========================================
    // byte-wise register loads
    // ========================================

    // low byte first, untouched bytes keep their old value
    always_ff @(posedge iCLK or posedge iRST) begin
        if (iRST) begin
            display_cycles <= '0;
            galvo_x        <= '0;
            galvo_y        <= '0;
        end else if (load) begin
            case (field)
                laser_cmd_pkg::F_DISP_LO:
                    display_cycles[0 +: `LC_BYTE_W] <= load_byte;
                laser_cmd_pkg::F_DISP_HI:
                    display_cycles[`LC_BYTE_W +: `LC_BYTE_W] <= load_byte;

                // galvo X
                laser_cmd_pkg::F_GX_B0:
                    galvo_x[0 +: `LC_BYTE_W] <= load_byte;
                laser_cmd_pkg::F_GX_B1:
                    galvo_x[`LC_BYTE_W +: `LC_BYTE_W] <= load_byte;
                laser_cmd_pkg::F_GX_B2:
                    galvo_x[2*`LC_BYTE_W +: `LC_BYTE_W] <= load_byte;

                // galvo Y
                laser_cmd_pkg::F_GY_B0:
                    galvo_y[0 +: `LC_BYTE_W] <= load_byte;
                laser_cmd_pkg::F_GY_B1:
                    galvo_y[`LC_BYTE_W +: `LC_BYTE_W] <= load_byte;
                laser_cmd_pkg::F_GY_B2:
                    galvo_y[2*`LC_BYTE_W +: `LC_BYTE_W] <= load_byte;

                // offset fields belong to the other bank
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire
